//--- logic/riscv_lsu_pkg.sv
package riscv_lsu_pkg;

  // address and data width
  localparam int data_width = 32;

  // operation class
  localparam int lsu_opt_width = 2;

  localparam logic [lsu_opt_width-1:0] lsu_opt_none  = 2'd0;
  localparam logic [lsu_opt_width-1:0] lsu_opt_load  = 2'd1;
  localparam logic [lsu_opt_width-1:0] lsu_opt_store = 2'd2;
  // 2'd3 is unused and behaves like lsu_opt_none

  // funct3 codes, signed forms shared by loads and stores
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;

  // zero-extending forms, loads only
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  // decode key is {lsu_opt, funct3}
  localparam int lsu_key_width = lsu_opt_width + 3;

endpackage

//--- logic/lsu_key_mux.sv
module lsu_key_mux #(
  parameter int nr_key   = 2,
  parameter int key_len  = 1,
  parameter int data_len = 1
) (
  input  logic [key_len-1:0]                   key,
  input  logic [data_len-1:0]                  default_out,
  input  logic [nr_key*(key_len+data_len)-1:0] lut,
  output logic [data_len-1:0]                  out
);

  localparam int pair_len = key_len + data_len;

  logic [pair_len-1:0] pair [nr_key];
  logic [nr_key-1:0]   hit;

  // split the flat table into {key, data} pairs
  always_comb begin
    for (int i = 0; i < nr_key; i++) begin
      pair[i] = lut[i*pair_len +: pair_len];
      hit[i]  = (pair[i][pair_len-1 -: key_len] == key);
    end
  end

  // keys are unique, so at most one hit is expected
  always_comb begin
    out = default_out;
    for (int i = 0; i < nr_key; i++) begin
      if (hit[i]) begin
        out = pair[i][data_len-1:0];
      end
    end
  end

endmodule

//--- logic/riscv_lsu.sv
module riscv_lsu #(
  parameter int mem_words = 256
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    req,
  input  logic [riscv_lsu_pkg::lsu_opt_width-1:0] lsu_opt,
  input  logic [2:0]                              funct3,
  input  logic [riscv_lsu_pkg::data_width-1:0]    addr,
  input  logic [riscv_lsu_pkg::data_width-1:0]    wdata,
  output logic                                    mem_en,
  output logic                                    mem_we,
  output logic [$clog2(mem_words)-1:0]            mem_word_addr,
  output logic [3:0]                              mem_byte_en,
  output logic [riscv_lsu_pkg::data_width-1:0]    mem_wdata,
  input  logic [riscv_lsu_pkg::data_width-1:0]    mem_rdata,
  output logic [riscv_lsu_pkg::data_width-1:0]    result,
  output logic                                    result_valid,
  output logic                                    fault
);

  localparam int idx_bits = $clog2(mem_words);
  localparam int dw       = riscv_lsu_pkg::data_width;

  logic [3:0] lane_pat;     // access size as lane pattern, 0 if illegal
  logic       is_mem_op;
  logic       misaligned;
  logic       access_ok;
  logic       req_fault;

  logic                                    load_pend;
  logic [2:0]                              load_f3;
  logic [1:0]                              load_off;
  logic [riscv_lsu_pkg::lsu_opt_width-1:0] ext_opt;
  logic [dw-1:0]                           rd_sh;

  lsu_key_mux #(
    .nr_key   (8),
    .key_len  (riscv_lsu_pkg::lsu_key_width),
    .data_len (4)
  ) lane_mux (
    .key         ({lsu_opt, funct3}),
    .default_out (4'b0000),
    .out         (lane_pat),
    .lut ({{riscv_lsu_pkg::lsu_opt_store, riscv_lsu_pkg::f3_byte},   4'b0001,  // sb
           {riscv_lsu_pkg::lsu_opt_store, riscv_lsu_pkg::f3_half},   4'b0011,  // sh
           {riscv_lsu_pkg::lsu_opt_store, riscv_lsu_pkg::f3_word},   4'b1111,  // sw
           {riscv_lsu_pkg::lsu_opt_load,  riscv_lsu_pkg::f3_byte},   4'b0001,  // lb
           {riscv_lsu_pkg::lsu_opt_load,  riscv_lsu_pkg::f3_half},   4'b0011,  // lh
           {riscv_lsu_pkg::lsu_opt_load,  riscv_lsu_pkg::f3_word},   4'b1111,  // lw
           {riscv_lsu_pkg::lsu_opt_load,  riscv_lsu_pkg::f3_byte_u}, 4'b0001,  // lbu
           {riscv_lsu_pkg::lsu_opt_load,  riscv_lsu_pkg::f3_half_u}, 4'b0011}) // lhu
  );

  assign is_mem_op = (lsu_opt == riscv_lsu_pkg::lsu_opt_load) ||
                     (lsu_opt == riscv_lsu_pkg::lsu_opt_store);

  // half needs bit 0 clear, word needs bits 1:0 clear
  assign misaligned = (addr[0] && lane_pat[1]) || (addr[1] && lane_pat[3]);

  assign access_ok = req && (lane_pat != 4'b0000) && !misaligned;
  assign req_fault = req && is_mem_op && !access_ok;

  assign mem_en        = access_ok;
  assign mem_we        = access_ok && (lsu_opt == riscv_lsu_pkg::lsu_opt_store);
  assign mem_word_addr = addr[idx_bits+1:2];  // upper bits ignored, index wraps
  assign mem_byte_en   = access_ok ? (lane_pat << addr[1:0]) : 4'b0000;
  assign mem_wdata     = wdata << {addr[1:0], 3'b000};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_pend <= 1'b0;
      fault     <= 1'b0;
    end else begin
      load_pend <= mem_en && !mem_we;
      fault     <= req_fault;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_en && !mem_we) begin
      load_f3  <= funct3;
      load_off <= addr[1:0];
    end
  end

  // selected byte or half lands in the low bits
  assign rd_sh   = mem_rdata >> {load_off, 3'b000};
  assign ext_opt = load_pend ? riscv_lsu_pkg::lsu_opt_load : riscv_lsu_pkg::lsu_opt_none;

  lsu_key_mux #(
    .nr_key   (5),
    .key_len  (riscv_lsu_pkg::lsu_key_width),
    .data_len (dw)
  ) ext_mux (
    .key         ({ext_opt, load_f3}),
    .default_out ({dw{1'b0}}),  // idle cycles read as zero
    .out         (result),
    .lut ({{riscv_lsu_pkg::lsu_opt_load, riscv_lsu_pkg::f3_byte},
           {{(dw-8){rd_sh[7]}}, rd_sh[7:0]},
           {riscv_lsu_pkg::lsu_opt_load, riscv_lsu_pkg::f3_half},
           {{(dw-16){rd_sh[15]}}, rd_sh[15:0]},
           {riscv_lsu_pkg::lsu_opt_load, riscv_lsu_pkg::f3_word},
           rd_sh,
           {riscv_lsu_pkg::lsu_opt_load, riscv_lsu_pkg::f3_byte_u},
           {{(dw-8){1'b0}}, rd_sh[7:0]},
           {riscv_lsu_pkg::lsu_opt_load, riscv_lsu_pkg::f3_half_u},
           {{(dw-16){1'b0}}, rd_sh[15:0]}})
  );

  assign result_valid = load_pend;

endmodule

//--- logic/data_ram.sv
module data_ram #(
  parameter int mem_words = 256
) (
  input  logic                                 clk,
  input  logic                                 en,
  input  logic                                 we,
  input  logic [$clog2(mem_words)-1:0]         word_addr,
  input  logic [3:0]                           byte_en,
  input  logic [riscv_lsu_pkg::data_width-1:0] wdata,
  output logic [riscv_lsu_pkg::data_width-1:0] rdata
);

  logic [riscv_lsu_pkg::data_width-1:0] mem [mem_words];

  // byte lane writes
  always_ff @(posedge clk) begin
    if (en && we) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_en[i]) begin
          mem[word_addr][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk) begin
    if (en && !we) begin
      rdata <= mem[word_addr];
    end
  end

endmodule

//--- logic/lsu_subsystem.sv
module lsu_subsystem #(
  parameter int mem_words = 256
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    req,
  input  logic [riscv_lsu_pkg::lsu_opt_width-1:0] lsu_opt,
  input  logic [2:0]                              funct3,
  input  logic [riscv_lsu_pkg::data_width-1:0]    addr,
  input  logic [riscv_lsu_pkg::data_width-1:0]    wdata,
  output logic [riscv_lsu_pkg::data_width-1:0]    result,
  output logic                                    result_valid,
  output logic                                    fault
);

  logic                                 mem_en;
  logic                                 mem_we;
  logic [$clog2(mem_words)-1:0]         mem_word_addr;
  logic [3:0]                           mem_byte_en;
  logic [riscv_lsu_pkg::data_width-1:0] mem_wdata;
  logic [riscv_lsu_pkg::data_width-1:0] mem_rdata;

  riscv_lsu #(
    .mem_words (mem_words)
  ) riscv_lsu_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req           (req),
    .lsu_opt       (lsu_opt),
    .funct3        (funct3),
    .addr          (addr),
    .wdata         (wdata),
    .mem_en        (mem_en),
    .mem_we        (mem_we),
    .mem_word_addr (mem_word_addr),
    .mem_byte_en   (mem_byte_en),
    .mem_wdata     (mem_wdata),
    .mem_rdata     (mem_rdata),
    .result        (result),
    .result_valid  (result_valid),
    .fault         (fault)
  );

  data_ram #(
    .mem_words (mem_words)
  ) data_ram_inst (
    .clk       (clk),
    .en        (mem_en),
    .we        (mem_we),
    .word_addr (mem_word_addr),
    .byte_en   (mem_byte_en),
    .wdata     (mem_wdata),
    .rdata     (mem_rdata)
  );

endmodule

//--- include/tb_lsu_util.svh
`ifndef TB_LSU_UTIL_SVH
`define TB_LSU_UTIL_SVH

localparam int shadow_bytes = 4 * 256;  // matches mem_words of 256

logic [7:0] shadow_mem [shadow_bytes];

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic int access_bytes(input logic [2:0] f3);
  return (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
endfunction

// fault if funct3 illegal for the op or address misaligned
function automatic bit expect_fault(input logic [1:0] opt, input logic [2:0] f3,
                                    input logic [31:0] addr);
  bit legal;
  legal = (opt == riscv_lsu_pkg::lsu_opt_load) ?
          (f3 != 3'b011 && f3 != 3'b110 && f3 != 3'b111) : (f3[2] == 1'b0 && f3 != 3'b011);
  if (opt != riscv_lsu_pkg::lsu_opt_load && opt != riscv_lsu_pkg::lsu_opt_store) return 1'b0;
  if (!legal) return 1'b1;
  return (addr % access_bytes(f3)) != 0;
endfunction

function automatic void shadow_store(input logic [31:0] addr, input logic [2:0] f3,
                                     input logic [31:0] data);
  for (int i = 0; i < access_bytes(f3); i++) begin
    shadow_mem[(addr + i) % shadow_bytes] = data[8*i +: 8];
  end
endfunction

// extracted and extended load value
function automatic logic [31:0] expect_load(input logic [31:0] addr, input logic [2:0] f3);
  logic [31:0] raw;
  raw = '0;
  for (int i = 0; i < access_bytes(f3); i++) begin
    raw[8*i +: 8] = shadow_mem[(addr + i) % shadow_bytes];
  end
  case (f3)
    riscv_lsu_pkg::f3_byte: return {{24{raw[7]}}, raw[7:0]};
    riscv_lsu_pkg::f3_half: return {{16{raw[15]}}, raw[15:0]};
    default:                return raw;
  endcase
endfunction

`endif

//--- verification/tb_lsu_subsystem.sv
module tb_lsu_subsystem;
  timeunit 1ns;
  timeprecision 1ps;

  `include "tb_lsu_util.svh"

  logic        clk;
  logic        rst_n;
  logic        req;
  logic [1:0]  lsu_opt;
  logic [2:0]  funct3;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] result;
  logic        result_valid;
  logic        fault;

  logic [31:0] lfsr_state;
  int          error_count;
  int          timeout_count;
  int          cycle_no;
  bit          check_idle_zero;

  // one entry per load or fault in request order
  int          exp_due [$];
  bit          exp_fault [$];
  logic [31:0] exp_data [$];

  lsu_subsystem #(
    .mem_words (256)
  ) lsu_subsystem_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .lsu_opt      (lsu_opt),
    .funct3       (funct3),
    .addr         (addr),
    .wdata        (wdata),
    .result       (result),
    .result_valid (result_valid),
    .fault        (fault)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [2:0] rand_store_f3();
    case (rand_bits(2))
      0:       return riscv_lsu_pkg::f3_byte;
      1:       return riscv_lsu_pkg::f3_half;
      default: return riscv_lsu_pkg::f3_word;
    endcase
  endfunction

  function automatic logic [2:0] rand_load_f3();
    case (rand_bits(3) % 5)
      0:       return riscv_lsu_pkg::f3_byte;
      1:       return riscv_lsu_pkg::f3_half;
      2:       return riscv_lsu_pkg::f3_word;
      3:       return riscv_lsu_pkg::f3_byte_u;
      default: return riscv_lsu_pkg::f3_half_u;
    endcase
  endfunction

  function automatic logic [31:0] align_addr(input logic [31:0] a, input logic [2:0] f3);
    return a & ~(32'(access_bytes(f3)) - 32'd1);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_responses();
    bit          flt;
    logic [31:0] d;
    if (exp_due.size() > 0 && exp_due[0] == cycle_no) begin
      flt = exp_fault.pop_front();
      d   = exp_data.pop_front();
      void'(exp_due.pop_front());
      check_value("result_valid", 32'(result_valid), 32'(!flt));
      check_value("fault", 32'(fault), 32'(flt));
      if (!flt) check_value("result", result, d);
    end else begin
      check_value("result_valid", 32'(result_valid), 32'h0);
      check_value("fault", 32'(fault), 32'h0);
      if (check_idle_zero) check_value("result", result, 32'h0);
    end
  endtask

  function automatic void model_request(input logic [1:0] opt, input logic [2:0] f3,
                                        input logic [31:0] a, input logic [31:0] d);
    if (expect_fault(opt, f3, a)) begin
      exp_due.push_back(cycle_no + 1);
      exp_fault.push_back(1'b1);
      exp_data.push_back(32'h0);
    end else if (opt == riscv_lsu_pkg::lsu_opt_load) begin
      exp_due.push_back(cycle_no + 1);
      exp_fault.push_back(1'b0);
      exp_data.push_back(expect_load(a, f3));
    end else if (opt == riscv_lsu_pkg::lsu_opt_store) begin
      shadow_store(a, f3, d);
    end
  endfunction

  // check last cycle's response before driving this cycle's request
  task automatic run_cycle(input bit r, input logic [1:0] opt, input logic [2:0] f3,
                           input logic [31:0] a, input logic [31:0] d);
    @(negedge clk);
    check_responses();
    req     = r;
    lsu_opt = opt;
    funct3  = f3;
    addr    = a;
    wdata   = d;
    if (r) model_request(opt, f3, a, d);
    cycle_no++;
  endtask

  task automatic idle(input int n);
    repeat (n) run_cycle(1'b0, riscv_lsu_pkg::lsu_opt_none, 3'b000, 32'h0, 32'h0);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((exp_due.size() > 0 || result_valid || fault) && waited < 8) begin
      idle(1);
      waited++;
    end
    if (exp_due.size() > 0 || result_valid || fault) begin
      $display("timeout: DUT strobes still active after %0d idle cycles", waited);
      timeout_count++;
    end
    idle(1);
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] d;
    logic [2:0]  f3;
    logic [1:0]  off;
    int          n;
    lfsr_state      = 32'h5f3dc244;
    error_count     = 0;
    timeout_count   = 0;
    cycle_no        = 0;
    check_idle_zero = 1'b1;
    rst_n   = 1'b0;
    req     = 1'b0;
    lsu_opt = riscv_lsu_pkg::lsu_opt_none;
    funct3  = 3'b000;
    addr    = 32'h0;
    wdata   = 32'h0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    idle(20);  // quiet outputs after reset
    check_idle_zero = 1'b0;

    for (int w = 0; w < 256; w++) begin
      d = rand_bits(32);
      run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_store, riscv_lsu_pkg::f3_word, 32'(w * 4), d);
    end
    for (int w = 0; w < 256; w++) begin
      run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_load, riscv_lsu_pkg::f3_word, 32'(w * 4), 32'h0);
    end
    drain();

    for (int i = 0; i < 400; i++) begin
      a = rand_bits(12);  // upper bits exercise index wrap
      if (rand_bits(1) != 0) begin
        f3 = rand_store_f3();
        d  = rand_bits(32);
        run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_store, f3, align_addr(a, f3), d);
      end else begin
        f3 = rand_load_f3();
        run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_load, f3, align_addr(a, f3), 32'h0);
      end
      if (rand_bits(1) != 0) idle(1);
    end
    drain();

    for (int i = 0; i < 40; i++) begin
      a = rand_bits(12);
      if (rand_bits(1) != 0) begin
        f3   = riscv_lsu_pkg::f3_half;
        a[0] = 1'b1;
      end else begin
        f3      = riscv_lsu_pkg::f3_word;
        off     = 2'(rand_bits(2));
        a[1:0]  = (off == 2'b00) ? 2'b11 : off;
      end
      d = rand_bits(32);
      if (rand_bits(1) != 0) begin
        run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_store, f3, a, d);
      end else begin
        run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_load, f3, a, 32'h0);
      end
      run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_load, riscv_lsu_pkg::f3_word, {a[31:2], 2'b00}, 32'h0);
    end
    drain();

    // illegal load codes 011 110 111 and store codes 100 to 111
    for (int i = 0; i < 21; i++) begin
      a      = rand_bits(12);
      a[1:0] = 2'b00;
      d      = rand_bits(32);
      if (i % 7 < 3) begin
        f3 = (i % 7 == 0) ? 3'b011 : (i % 7 == 1) ? 3'b110 : 3'b111;
        run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_load, f3, a, d);
      end else begin
        f3 = 3'(i % 7 + 1);
        run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_store, f3, a, d);
      end
      run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_load, riscv_lsu_pkg::f3_word, a, 32'h0);
    end
    for (int i = 0; i < 20; i++) begin
      a  = rand_bits(12);
      f3 = 3'(rand_bits(3));
      d  = rand_bits(32);
      run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_none, f3, a, d);
    end
    drain();

    n = 0;
    while (n < 200) begin
      a = 32'h100 | rand_bits(4);  // small window for frequent reuse
      if (rand_bits(1) != 0) begin
        f3 = rand_store_f3();
        a  = align_addr(a, f3);
        d  = rand_bits(32);
        run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_store, f3, a, d);
        run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_load, riscv_lsu_pkg::f3_word,
                  {a[31:2], 2'b00}, 32'h0);
        n += 2;
      end else begin
        f3 = rand_load_f3();
        run_cycle(1'b1, riscv_lsu_pkg::lsu_opt_load, f3, align_addr(a, f3), 32'h0);
        n++;
      end
    end
    drain();

    $display("checks done: %0d errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
logic/riscv_lsu_pkg.sv
logic/lsu_key_mux.sv
logic/riscv_lsu.sv
logic/data_ram.sv
logic/lsu_subsystem.sv
verification/tb_lsu_subsystem.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_lsu_subsystem
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
